// File: design/fp32_uart_tx.sv
`timescale 1ns/1ps

module fp32_uart_tx
    import uart_tx_pkg::*;
(
    input  logic  CLK_I,
    input  logic  RSTL_I,
    input  logic  tx_valid,
    input  word_t tx_data,
    output logic  tx_ready,
    output logic  tx_line
);

    logic  byte_valid;
    byte_t byte_data;
    logic  byte_ready;
    logic  bit_tick;
    logic  run;

    word_tx_ctrl u_word_tx_ctrl (
        .CLK_I      (CLK_I),
        .RSTL_I     (RSTL_I),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_ready   (tx_ready),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_ready (byte_ready),
        .bit_tick   (bit_tick),
        .run        (run)
    );

    uart_frame_tx u_uart_frame_tx (
        .CLK_I      (CLK_I),
        .RSTL_I     (RSTL_I),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_ready (byte_ready),
        .bit_tick   (bit_tick),
        .tx_line    (tx_line)
    );

    // shared bit timing for sequencer and serializer
    uart_baud_gen u_uart_baud_gen (
        .CLK_I    (CLK_I),
        .RSTL_I   (RSTL_I),
        .run      (run),
        .bit_tick (bit_tick)
    );

endmodule

// File: design/uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen
    import uart_tx_pkg::*;
(
    input  logic CLK_I,
    input  logic RSTL_I,
    input  logic run,
    output logic bit_tick
);

    baud_cnt_t baud_cnt;

    // count only leaves zero while running, so a terminal count means a live bit boundary
    assign bit_tick = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            baud_cnt <= '0;
        end else if (!run || bit_tick) begin
            baud_cnt <= '0; // restart aligned to the next bit
        end else begin
            baud_cnt <= baud_cnt + baud_cnt_t'(1);
        end
    end

endmodule

// File: design/uart_frame_tx.sv
`timescale 1ns/1ps

module uart_frame_tx
    import uart_tx_pkg::*;
(
    input  logic  CLK_I,
    input  logic  RSTL_I,
    input  logic  byte_valid,
    input  byte_t byte_data,
    output logic  byte_ready,
    input  logic  bit_tick,
    output logic  tx_line
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } frame_state_t;

    frame_state_t state;
    byte_t        shift_q;
    bit_idx_t     bit_idx;
    logic         load;
    logic         last_bit;

    // ready again in the cycle whose tick closes the stop bit
    assign byte_ready = (state == ST_IDLE) || ((state == ST_STOP) && bit_tick);
    assign load       = byte_valid && byte_ready;
    assign last_bit   = (bit_idx == bit_idx_t'(BITS_PER_BYTE - 1));

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            state   <= ST_IDLE;
            bit_idx <= '0;
            tx_line <= 1'b1; // line idles high
        end else if (load) begin
            state   <= ST_START;
            bit_idx <= '0;
            tx_line <= 1'b0; // start bit
        end else if (bit_tick) begin
            case (state)
                ST_START: begin
                    state   <= ST_DATA;
                    tx_line <= shift_q[0];
                end
                ST_DATA: begin
                    if (last_bit) begin
                        state   <= ST_STOP;
                        tx_line <= 1'b1; // stop bit
                    end else begin
                        bit_idx <= bit_idx + bit_idx_t'(1);
                        tx_line <= shift_q[1]; // next bit, shift happens this edge
                    end
                end
                ST_STOP: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state   <= ST_IDLE;
                    tx_line <= 1'b1;
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge CLK_I) begin
        if (load) begin
            shift_q <= byte_data;
        end else if (bit_tick && (state == ST_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: design/uart_tx_pkg.sv
package uart_tx_pkg;

    localparam int CLK_FREQ_HZ    = 50_000_000;
    localparam int BAUD_RATE      = 115_200;
    localparam int CLKS_PER_BIT   = CLK_FREQ_HZ / BAUD_RATE; // 434 at 50 MHz
    localparam int BITS_PER_BYTE  = 8;
    localparam int BYTES_PER_WORD = 4;

    localparam int WORD_W     = BITS_PER_BYTE * BYTES_PER_WORD;
    localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_IDX_W  = $clog2(BITS_PER_BYTE);
    localparam int BYTE_IDX_W = $clog2(BYTES_PER_WORD);

    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [BITS_PER_BYTE-1:0] byte_t;
    typedef logic [BAUD_CNT_W-1:0]    baud_cnt_t;
    typedef logic [BIT_IDX_W-1:0]     bit_idx_t;
    typedef logic [BYTE_IDX_W-1:0]    byte_idx_t;

endpackage

// File: design/word_tx_ctrl.sv
`timescale 1ns/1ps

module word_tx_ctrl
    import uart_tx_pkg::*;
(
    input  logic  CLK_I,
    input  logic  RSTL_I,
    input  logic  tx_valid,
    input  word_t tx_data,
    output logic  tx_ready,
    output logic  byte_valid,
    output byte_t byte_data,
    input  logic  byte_ready,
    input  logic  bit_tick,
    output logic  run
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_GAP
    } ctrl_state_t;

    ctrl_state_t state;
    word_t       word_q;
    byte_idx_t   byte_idx;
    logic        frame_done;
    logic        last_byte;
    logic        accept;

    // byte already handed over and the serializer has come back
    assign frame_done = (state == ST_SEND) && !byte_valid && byte_ready;
    assign last_byte  = (byte_idx == byte_idx_t'(BYTES_PER_WORD - 1));

    // ready in the last stop-bit cycle so words go out back to back
    assign tx_ready = (state == ST_IDLE) || (frame_done && last_byte);
    assign run      = !tx_ready;
    assign accept   = tx_valid && tx_ready;

    assign byte_data = word_q[byte_idx * BITS_PER_BYTE +: BITS_PER_BYTE];

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            state      <= ST_IDLE;
            byte_idx   <= '0;
            byte_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state      <= ST_SEND;
                        byte_idx   <= '0;
                        byte_valid <= 1'b1; // byte 0 offered right away
                    end
                end
                ST_SEND: begin
                    if (byte_valid && byte_ready) begin
                        byte_valid <= 1'b0;
                    end else if (frame_done && !last_byte) begin
                        state    <= ST_GAP;
                        byte_idx <= byte_idx + byte_idx_t'(1);
                    end else if (frame_done && accept) begin
                        byte_idx   <= '0; // next word follows directly
                        byte_valid <= 1'b1;
                    end else if (frame_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_GAP: begin
                    if (bit_tick) begin // one idle bit between frames
                        state      <= ST_SEND;
                        byte_valid <= 1'b1;
                    end
                end
                default: begin
                    state      <= ST_IDLE;
                    byte_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge CLK_I) begin
        if (accept) begin
            word_q <= tx_data;
        end
    end

endmodule

// File: fp32_uart_tx.f
design/uart_tx_pkg.sv
design/uart_baud_gen.sv
design/uart_frame_tx.sv
design/word_tx_ctrl.sv
design/fp32_uart_tx.sv
verif/tb_fp32_uart_tx.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the fp32_uart_tx testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    --top-module tb_fp32_uart_tx \
    -f fp32_uart_tx.f \
    -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "run.sh: simulation reported failure"
    exit 1
fi

echo "run.sh: simulation completed without failure"

// File: verif/tb_fp32_uart_tx.sv
`timescale 1ns/1ps

module tb_fp32_uart_tx
    import uart_tx_pkg::*;
;

    localparam int          CLK_HALF_NS  = 4;
    localparam int          RESET_CYCLES = 4;
    localparam int          RESET_IDLE   = 20;
    localparam int          BUSY_CHANGES = 100;
    localparam int          RANDOM_WORDS = 6;
    localparam int          NUM_WORDS    = 4 + RANDOM_WORDS;
    localparam int          FRAME_CYCLES = 11 * CLKS_PER_BIT; // 10 frame bits plus gap
    localparam int          WORD_CYCLES  = 43 * CLKS_PER_BIT;
    localparam int          TIMEOUT_CYCLES = NUM_WORDS * WORD_CYCLES + 2000;
    localparam logic [31:0] RAND_SEED    = 32'h4d7a_397c;

    logic  CLK_I;
    logic  RSTL_I;
    logic  tx_valid;
    word_t tx_data;
    logic  tx_ready;
    logic  tx_line;

    int    cyc = 0;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    byte_t exp_byte_q[$];
    int    exp_cyc_q[$];
    byte_t rx_byte_q[$];
    int    rx_cyc_q[$];

    fp32_uart_tx dut0 (
        .CLK_I    (CLK_I),
        .RSTL_I   (RSTL_I),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .tx_line  (tx_line)
    );

    initial begin
        CLK_I = 1'b0;
        forever #(CLK_HALF_NS) CLK_I = ~CLK_I;
    end

    always @(posedge CLK_I) begin
        cyc <= cyc + 1; // read at negedge, so it holds the number of the last edge
    end

    // byte idx of a word, least significant first
    function automatic byte_t expected_byte(input word_t w, input byte_idx_t idx);
        word_t shifted;
        shifted = w >> (int'(idx) * BITS_PER_BYTE);
        return shifted[BITS_PER_BYTE-1:0];
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic queue_expected(input word_t w, input int acc_edge);
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            exp_byte_q.push_back(expected_byte(w, byte_idx_t'(i)));
            exp_cyc_q.push_back(acc_edge + 1 + i * FRAME_CYCLES); // start bit one cycle late
        end
    endtask

    // call in the active region of a rising edge, returns on the accepting edge
    task automatic send_word(input word_t w, input logic hold, output int acc_edge);
        tx_valid <= 1'b1;
        tx_data  <= w;
        @(negedge CLK_I);
        while (!tx_ready) begin
            @(negedge CLK_I);
        end
        acc_edge = cyc + 1;
        queue_expected(w, acc_edge);
        @(posedge CLK_I);
        if (!hold) begin
            tx_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_byte_q.size() > 0) begin
            @(negedge CLK_I);
        end
        repeat (4) @(negedge CLK_I);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_start);
        end
    endtask

    // samples each frame at mid-bit
    initial begin : line_monitor
        logic  prev_line;
        byte_t rx;
        int    fall_cyc;
        prev_line = 1'b1;
        forever begin
            @(negedge CLK_I);
            if (RSTL_I && prev_line && !tx_line) begin
                fall_cyc = cyc;
                repeat (CLKS_PER_BIT / 2) @(negedge CLK_I);
                check_bit("tx_line", tx_line, 1'b0); // start bit
                for (int i = 0; i < BITS_PER_BYTE; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge CLK_I);
                    rx[i] = tx_line;
                end
                repeat (CLKS_PER_BIT) @(negedge CLK_I);
                check_bit("tx_line", tx_line, 1'b1); // stop bit
                rx_byte_q.push_back(rx);
                rx_cyc_q.push_back(fall_cyc);
            end
            prev_line = tx_line;
        end
    end

    initial begin : compare_rx
        byte_t got_b;
        byte_t exp_b;
        int    got_c;
        int    exp_c;
        forever begin
            @(posedge CLK_I);
            while (rx_byte_q.size() > 0) begin
                got_b = rx_byte_q.pop_front();
                got_c = rx_cyc_q.pop_front();
                if (exp_byte_q.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: byte %02h received while no word was sent",
                             $time, got_b);
                end else begin
                    exp_b = exp_byte_q.pop_front();
                    exp_c = exp_cyc_q.pop_front();
                    check_byte("rx_byte", got_b, exp_b);
                    check_cycles("start_edge_cycle", got_c, exp_c);
                end
            end
        end
    end

    initial begin : watchdog
        while (cyc < TIMEOUT_CYCLES) begin
            @(posedge CLK_I);
        end
        $display("ERROR: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main_seq
        int    acc_a;
        int    acc_b;
        int    prev_acc;
        int    ready_edge;
        int    err_start;
        word_t w;
        void'($urandom(RAND_SEED));
        RSTL_I   = 1'b0;
        tx_valid = 1'b0;
        tx_data  = '0;
        repeat (RESET_CYCLES) @(posedge CLK_I);
        RSTL_I <= 1'b1;

        err_start = errors;
        repeat (RESET_IDLE) begin
            @(negedge CLK_I);
            check_bit("tx_ready", tx_ready, 1'b1);
            check_bit("tx_line", tx_line, 1'b1);
        end
        report_test("reset state", err_start);

        err_start = errors;
        @(posedge CLK_I);
        send_word(32'h4443_4241, 1'b0, acc_a);
        @(negedge CLK_I);
        check_bit("tx_ready", tx_ready, 1'b0);
        while (!tx_ready) begin
            @(negedge CLK_I);
        end
        ready_edge = cyc + 1;
        check_cycles("tx_ready_return", ready_edge - acc_a, WORD_CYCLES);
        wait_drain();
        report_test("single word", err_start);

        err_start = errors;
        @(posedge CLK_I);
        send_word(32'hf05a_a50f, 1'b0, acc_a); // edges checked by compare_rx
        wait_drain();
        report_test("frame spacing", err_start);

        err_start = errors;
        @(posedge CLK_I);
        send_word(32'h1234_5678, 1'b0, acc_a);
        repeat (BUSY_CHANGES) begin
            @(posedge CLK_I);
            tx_data <= $urandom; // must not reach the line
            @(negedge CLK_I);
            check_bit("tx_ready", tx_ready, 1'b0);
        end
        @(posedge CLK_I);
        send_word(32'h9abc_def0, 1'b0, acc_b);
        check_cycles("second_accept_edge", acc_b - acc_a, WORD_CYCLES);
        wait_drain();
        report_test("back-pressure", err_start);

        err_start = errors;
        prev_acc = 0;
        @(posedge CLK_I);
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            w = $urandom;
            send_word(w, (i < RANDOM_WORDS - 1), acc_b);
            if (i > 0) begin
                check_cycles("stream_accept_edge", acc_b - prev_acc, WORD_CYCLES);
            end
            prev_acc = acc_b;
        end
        wait_drain();
        report_test("random stream", err_start);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
